//--- flist.f
verilog/raybox_regs_pkg.sv
verilog/spi_sync.sv
verilog/spi_frame_rx.sv
verilog/vreg_bank.sv
verilog/spi_registers.sv
test/spi_registers_chk.sv
test/spi_registers_tb.sv

//--- Makefile
# Verilator build and run for the SPI register file
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= spi_registers_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS SIM_ARGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test: pass"; \
	else \
	  echo "test: fail, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/spi_registers_tb.sv
`timescale 1ns/1ps

module spi_registers_tb;

  import raybox_regs_pkg::*;

  localparam int   RESET_CYCLES   = 16;
  localparam int   HALF_CYCLES    = 4;    // SPI half-period in clk cycles
  localparam int   CYCLES_PER_ROW = 400;  // Watchdog budget per table row
  localparam int   MAX_ROWS       = 32;
  localparam rgb_t SKY_INIT       = 6'b01_01_01;
  localparam rgb_t FLOOR_INIT     = 6'b10_10_10;

  // Expected state of every live output
  typedef struct packed {
    logic [5:0] sky;
    logic [5:0] floor;
    logic [5:0] leak;
    logic [5:0] otherx;
    logic [5:0] othery;
    logic [5:0] vshift;
    logic [5:0] mapdx;
    logic [5:0] mapdy;
    logic [1:0] mapdxw;
    logic [1:0] mapdyw;
    logic       vinf;
    logic       leakfixed;
  } regs_t;

  typedef struct packed {
    logic [3:0]  cmd;
    logic [15:0] payload;   // Low bits sent, MSB first
    logic        drop;      // Release select before the last payload bit
    logic        load;      // Pulse i_load_new after the frame
    regs_t       exp_regs;  // Live outputs after the row
  } row_t;

  logic     clk;
  logic     reset;
  logic     sclk;
  logic     ss_n;
  logic     mosi;
  logic     load_new;
  rgb_t     sky, floor;
  cell6_t   leak, otherx, othery, vshift, mapdx, mapdy;
  wall_id_t mapdxw, mapdyw;
  logic     vinf, leakfixed;

  row_t   rows [MAX_ROWS];
  int     n_rows;
  regs_t  stg_model;    // Model of the staging registers
  regs_t  live_model;   // Model of the live outputs
  integer seed = 32'he6d9_d2da;
  bit     table_ready = 1'b0;

  spi_registers #(
    .SYNC_STAGES (2),
    .SKY_INIT    (SKY_INIT),
    .FLOOR_INIT  (FLOOR_INIT)
  ) i_spi_registers (
    .clk (clk), .reset (reset),
    .i_sclk (sclk), .i_ss_n (ss_n), .i_mosi (mosi), .i_load_new (load_new),
    .o_sky (sky), .o_floor (floor), .o_leak (leak),
    .o_otherx (otherx), .o_othery (othery), .o_vshift (vshift),
    .o_mapdx (mapdx), .o_mapdy (mapdy), .o_mapdxw (mapdxw), .o_mapdyw (mapdyw),
    .o_vinf (vinf), .o_leakfixed (leakfixed)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic compare(input string name, input logic [15:0] exp_val,
                         input logic [15:0] act_val);
    if (act_val !== exp_val) begin
      $display("mismatch at %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, exp_val, act_val);
      abort_run("output check failed");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);  // Inputs always move after a falling edge
  endtask

  function automatic int payload_len(input logic [3:0] cmd);
    case (cmd)
      CMD_SKY:    return int'(LEN_SKY);
      CMD_FLOOR:  return int'(LEN_FLOOR);
      CMD_LEAK:   return int'(LEN_LEAK);
      CMD_OTHER:  return int'(LEN_OTHER);
      CMD_VSHIFT: return int'(LEN_VSHIFT);
      CMD_MAPD:   return int'(LEN_MAPD);
      default:    return int'(LEN_VOPTS);  // Also codes 7..15
    endcase
  endfunction

  function automatic regs_t reset_regs();
    regs_t r;
    r       = '0;
    r.sky   = SKY_INIT;
    r.floor = FLOOR_INIT;
    return r;
  endfunction

  // Field placement of each command, fields taken from the low end
  function automatic regs_t decode_frame(input regs_t r, input logic [3:0] cmd,
                                         input logic [15:0] p);
    regs_t n;
    n = r;
    case (cmd)
      CMD_SKY:    n.sky    = p[5:0];
      CMD_FLOOR:  n.floor  = p[5:0];
      CMD_LEAK:   n.leak   = p[5:0];
      CMD_VSHIFT: n.vshift = p[5:0];
      CMD_OTHER: begin
        n.otherx = p[11:6];  // X is sent first
        n.othery = p[5:0];
      end
      CMD_VOPTS: begin
        n.vinf      = p[1];
        n.leakfixed = p[0];
      end
      CMD_MAPD: begin
        n.mapdx  = p[15:10];
        n.mapdy  = p[9:4];
        n.mapdxw = p[3:2];
        n.mapdyw = p[1:0];
      end
      default: ;  // Unused codes write nothing
    endcase
    return n;
  endfunction

  function automatic logic [15:0] rand16();
    return 16'($random(seed));
  endfunction

  task automatic add_row(input logic [3:0] cmd, input logic [15:0] payload,
                         input logic drop, input logic load);
    if (!drop) stg_model = decode_frame(stg_model, cmd, payload);
    if (load) live_model = stg_model;
    rows[n_rows].cmd      = cmd;
    rows[n_rows].payload  = payload;
    rows[n_rows].drop     = drop;
    rows[n_rows].load     = load;
    rows[n_rows].exp_regs = live_model;
    n_rows++;
  endtask

  task automatic build_table();
    int round;
    int c;
    stg_model  = reset_regs();
    live_model = stg_model;
    n_rows     = 0;
    for (round = 0; round < 2; round++) begin
      for (c = 0; c < 7; c++) add_row(4'(c), rand16(), 1'b0, 1'b1);
    end
    add_row(CMD_SKY, rand16(), 1'b0, 1'b0);    // Staged only
    add_row(CMD_FLOOR, rand16(), 1'b0, 1'b1);  // Load picks up sky as well
    add_row(CMD_OTHER, rand16(), 1'b1, 1'b1);  // Partial frames
    add_row(CMD_MAPD, rand16(), 1'b1, 1'b1);
    for (c = 7; c < 16; c++) add_row(4'(c), rand16(), 1'b0, 1'b1);
    add_row(CMD_LEAK, rand16(), 1'b0, 1'b0);   // Overwritten before the load
    add_row(CMD_LEAK, rand16(), 1'b0, 1'b1);
  endtask

  // Command MSB first, then the payload; drop cuts the final bit
  task automatic send_frame(input logic [3:0] cmd, input logic [15:0] payload,
                            input logic drop);
    int len;
    int nbits;
    int i;
    len   = payload_len(cmd);
    nbits = CMD_BITS + len - (drop ? 1 : 0);
    ss_n  = 1'b0;
    idle(HALF_CYCLES);
    for (i = 0; i < nbits; i++) begin
      if (i < CMD_BITS) mosi = cmd[CMD_BITS-1-i];
      else mosi = payload[len-1-(i-CMD_BITS)];
      sclk = 1'b0;
      idle(HALF_CYCLES);
      sclk = 1'b1;  // Sampled on this edge
      idle(HALF_CYCLES);
    end
    sclk = 1'b0;
    idle(HALF_CYCLES);
    ss_n = 1'b1;
    idle(HALF_CYCLES);
  endtask

  task automatic check_regs(input regs_t e);
    compare("o_sky", 16'(e.sky), 16'(sky));
    compare("o_floor", 16'(e.floor), 16'(floor));
    compare("o_leak", 16'(e.leak), 16'(leak));
    compare("o_otherx", 16'(e.otherx), 16'(otherx));
    compare("o_othery", 16'(e.othery), 16'(othery));
    compare("o_vshift", 16'(e.vshift), 16'(vshift));
    compare("o_mapdx", 16'(e.mapdx), 16'(mapdx));
    compare("o_mapdy", 16'(e.mapdy), 16'(mapdy));
    compare("o_mapdxw", 16'(e.mapdxw), 16'(mapdxw));
    compare("o_mapdyw", 16'(e.mapdyw), 16'(mapdyw));
    compare("o_vinf", 16'(e.vinf), 16'(vinf));
    compare("o_leakfixed", 16'(e.leakfixed), 16'(leakfixed));
  endtask

  task automatic run_row(input row_t row);
    send_frame(row.cmd, row.payload, row.drop);
    idle(HALF_CYCLES);
    if (row.load) begin
      load_new = 1'b1;  // One-cycle strobe
      idle(1);
      load_new = 1'b0;
    end
    idle(2);
    check_regs(row.exp_regs);
  endtask

  // Failures counted by the bound checkers
  function automatic int unsigned assert_fails();
    return i_spi_registers.i_spi_frame_rx.i_frame_chk.fail_cnt
         + i_spi_registers.i_vreg_bank.i_bank_chk.fail_cnt;
  endfunction

  always @(negedge clk) begin
    if (assert_fails() != 0) begin
      $display("a bound assertion failed at %0t", $time);
      abort_run("assertion failure");
    end
  end

  initial begin
    wait (table_ready);
    repeat (RESET_CYCLES + n_rows * CYCLES_PER_ROW) @(posedge clk);
    $display("timeout: the test sequence did not finish in time");
    abort_run("watchdog expired");
  end

  initial begin
    int r;
    reset    = 1'b1;
    sclk     = 1'b0;
    ss_n     = 1'b1;
    mosi     = 1'b0;
    load_new = 1'b0;
    build_table();
    table_ready = 1'b1;
    idle(RESET_CYCLES);
    reset = 1'b0;
    idle(2);
    check_regs(reset_regs());  // Init colours, zero elsewhere
    for (r = 0; r < n_rows; r++) run_row(rows[r]);
    if (assert_fails() != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failure");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- test/spi_registers_chk.sv
`timescale 1ns/1ps

module spi_registers_chk #(
  parameter int LIVE_BITS = 54  // All live outputs side by side
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 i_frame_done,
  input logic                 i_ss_active,  // Tied high where select is not visible
  input logic                 i_load_new,   // Tied high where no live outputs exist
  input logic [LIVE_BITS-1:0] i_live
);

  int unsigned fail_cnt = 0;  // Polled by the testbench

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    i_frame_done |=> !i_frame_done)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("frame done held high for two cycles");
    end

  // No commit outside a select window
  a_done_in_window: assert property (@(posedge clk) disable iff (reset)
    !i_ss_active |-> !i_frame_done)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("frame done while select inactive");
    end

  a_live_on_load: assert property (@(posedge clk) disable iff (reset)
    (i_live != $past(i_live)) |-> $past(i_load_new))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("live outputs changed without a load");
    end

endmodule

bind spi_frame_rx spi_registers_chk i_frame_chk (
  .clk (clk), .reset (reset), .i_frame_done (o_frame_done),
  .i_ss_active (i_ss_active), .i_load_new (1'b1), .i_live ('0)
);

bind vreg_bank spi_registers_chk i_bank_chk (
  .clk (clk), .reset (reset), .i_frame_done (i_frame_done),
  .i_ss_active (1'b1), .i_load_new (i_load_new),
  .i_live ({o_sky, o_floor, o_leak, o_otherx, o_othery, o_vshift,
            o_mapdx, o_mapdy, o_mapdxw, o_mapdyw, o_vinf, o_leakfixed})
);

//--- verilog/spi_registers.sv
`timescale 1ns/1ps

module spi_registers #(
  parameter int                    SYNC_STAGES = 2,             // Synchroniser depth
  parameter raybox_regs_pkg::rgb_t SKY_INIT    = 6'b01_01_01,   // Sky after reset
  parameter raybox_regs_pkg::rgb_t FLOOR_INIT  = 6'b10_10_10    // Floor after reset
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_sclk,       // SPI from the host
  input  logic                      i_ss_n,
  input  logic                      i_mosi,
  input  logic                      i_load_new,   // From the renderer, once per frame
  output raybox_regs_pkg::rgb_t     o_sky,
  output raybox_regs_pkg::rgb_t     o_floor,
  output raybox_regs_pkg::cell6_t   o_leak,
  output raybox_regs_pkg::cell6_t   o_otherx,
  output raybox_regs_pkg::cell6_t   o_othery,
  output raybox_regs_pkg::cell6_t   o_vshift,
  output raybox_regs_pkg::cell6_t   o_mapdx,
  output raybox_regs_pkg::cell6_t   o_mapdy,
  output raybox_regs_pkg::wall_id_t o_mapdxw,
  output raybox_regs_pkg::wall_id_t o_mapdyw,
  output logic                      o_vinf,
  output logic                      o_leakfixed
);

  import raybox_regs_pkg::*;

  logic     sclk_rise;   // Clean SCLK edge pulse
  logic     ss_active;
  logic     mosi_sync;
  logic     frame_done;  // Commit pulse into the bank
  cmd_t     frame_cmd;
  payload_u frame_payload;

  // Bring the SPI pins into the clk domain
  spi_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_spi_sync (
    .clk         (clk),
    .reset       (reset),
    .i_sclk      (i_sclk),
    .i_ss_n      (i_ss_n),
    .i_mosi      (i_mosi),
    .o_sclk_rise (sclk_rise),
    .o_ss_active (ss_active),
    .o_mosi      (mosi_sync)
  );

  spi_frame_rx i_spi_frame_rx (
    .clk          (clk),
    .reset        (reset),
    .i_sclk_rise  (sclk_rise),
    .i_ss_active  (ss_active),
    .i_mosi       (mosi_sync),
    .o_frame_done (frame_done),
    .o_cmd        (frame_cmd),
    .o_payload    (frame_payload)
  );

  // Staging plus live registers
  vreg_bank #(
    .SKY_INIT   (SKY_INIT),
    .FLOOR_INIT (FLOOR_INIT)
  ) i_vreg_bank (
    .clk          (clk),
    .reset        (reset),
    .i_frame_done (frame_done),
    .i_cmd        (frame_cmd),
    .i_payload    (frame_payload),
    .i_load_new   (i_load_new),
    .o_sky        (o_sky),
    .o_floor      (o_floor),
    .o_leak       (o_leak),
    .o_otherx     (o_otherx),
    .o_othery     (o_othery),
    .o_vshift     (o_vshift),
    .o_mapdx      (o_mapdx),
    .o_mapdy      (o_mapdy),
    .o_mapdxw     (o_mapdxw),
    .o_mapdyw     (o_mapdyw),
    .o_vinf       (o_vinf),
    .o_leakfixed  (o_leakfixed)
  );

endmodule

//--- verilog/vreg_bank.sv
`timescale 1ns/1ps

module vreg_bank #(
  parameter raybox_regs_pkg::rgb_t SKY_INIT   = 6'b01_01_01,
  parameter raybox_regs_pkg::rgb_t FLOOR_INIT = 6'b10_10_10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_frame_done, // Commit strobe
  input  raybox_regs_pkg::cmd_t     i_cmd,
  input  raybox_regs_pkg::payload_u i_payload,
  input  logic                      i_load_new,   // Renderer says go live
  output raybox_regs_pkg::rgb_t     o_sky,
  output raybox_regs_pkg::rgb_t     o_floor,
  output raybox_regs_pkg::cell6_t   o_leak,       // Floor leak in texels
  output raybox_regs_pkg::cell6_t   o_otherx,
  output raybox_regs_pkg::cell6_t   o_othery,
  output raybox_regs_pkg::cell6_t   o_vshift,     // Texture V addend
  output raybox_regs_pkg::cell6_t   o_mapdx,      // Dividing wall on X, 0 for none
  output raybox_regs_pkg::cell6_t   o_mapdy,
  output raybox_regs_pkg::wall_id_t o_mapdxw,
  output raybox_regs_pkg::wall_id_t o_mapdyw,
  output logic                      o_vinf,       // Infinite V mode
  output logic                      o_leakfixed   // Leak pinned to the ground
);

  import raybox_regs_pkg::*;

  // Staging copies, waiting for the next load
  rgb_t     stg_sky;
  rgb_t     stg_floor;
  cell6_t   stg_leak;
  cell6_t   stg_otherx;
  cell6_t   stg_othery;
  cell6_t   stg_vshift;
  cell6_t   stg_mapdx;
  cell6_t   stg_mapdy;
  wall_id_t stg_mapdxw;
  wall_id_t stg_mapdyw;
  logic     stg_vinf;
  logic     stg_leakfixed;

  // Commit a finished frame into its staging register
  always_ff @(posedge clk) begin
    if (reset) begin
      stg_sky       <= SKY_INIT;
      stg_floor     <= FLOOR_INIT;
      stg_leak      <= '0;
      stg_otherx    <= '0;
      stg_othery    <= '0;
      stg_vshift    <= '0;
      stg_mapdx     <= '0;
      stg_mapdy     <= '0;
      stg_mapdxw    <= '0;
      stg_mapdyw    <= '0;
      stg_vinf      <= 1'b0;
      stg_leakfixed <= 1'b0;
    end else if (i_frame_done) begin
      case (i_cmd)
        CMD_SKY:    stg_sky    <= i_payload.single.value;
        CMD_FLOOR:  stg_floor  <= i_payload.single.value;
        CMD_LEAK:   stg_leak   <= i_payload.single.value;
        CMD_VSHIFT: stg_vshift <= i_payload.single.value;
        CMD_OTHER: begin
          stg_otherx <= i_payload.other.x;
          stg_othery <= i_payload.other.y;
        end
        CMD_VOPTS: begin
          stg_vinf      <= i_payload.vopts.vinf;
          stg_leakfixed <= i_payload.vopts.leakfixed;
        end
        CMD_MAPD: begin
          stg_mapdx  <= i_payload.mapd.mapdx;
          stg_mapdy  <= i_payload.mapd.mapdy;
          stg_mapdxw <= i_payload.mapd.mapdxw;
          stg_mapdyw <= i_payload.mapd.mapdyw;
        end
        default: ;  // Codes 7..15 are swallowed
      endcase
    end
  end

  // All live values move together on the load strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      o_sky       <= SKY_INIT;
      o_floor     <= FLOOR_INIT;
      o_leak      <= '0;
      o_otherx    <= '0;
      o_othery    <= '0;
      o_vshift    <= '0;
      o_mapdx     <= '0;
      o_mapdy     <= '0;
      o_mapdxw    <= '0;
      o_mapdyw    <= '0;
      o_vinf      <= 1'b0;
      o_leakfixed <= 1'b0;
    end else if (i_load_new) begin
      // A commit in this same cycle misses this load
      o_sky       <= stg_sky;
      o_floor     <= stg_floor;
      o_leak      <= stg_leak;
      o_otherx    <= stg_otherx;
      o_othery    <= stg_othery;
      o_vshift    <= stg_vshift;
      o_mapdx     <= stg_mapdx;
      o_mapdy     <= stg_mapdy;
      o_mapdxw    <= stg_mapdxw;
      o_mapdyw    <= stg_mapdyw;
      o_vinf      <= stg_vinf;
      o_leakfixed <= stg_leakfixed;
    end
  end

endmodule

//--- verilog/spi_frame_rx.sv
`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_sclk_rise,  // Sample strobe
  input  logic                      i_ss_active,  // Frame window
  input  logic                      i_mosi,
  output logic                      o_frame_done, // Pulses when the payload is complete
  output raybox_regs_pkg::cmd_t     o_cmd,
  output raybox_regs_pkg::payload_u o_payload
);

  import raybox_regs_pkg::*;

  logic [CNT_BITS-1:0]     bit_cnt;      // Bits taken in this select window
  cmd_t                    cmd_q;
  logic [PAYLOAD_BITS-1:0] rx_buf;       // Payload shifted in MSB first
  logic                    done_q;
  logic [CNT_BITS-1:0]     payload_len;  // Length for the current command
  logic [CNT_BITS-1:0]     last_bit;     // Counter value of the final payload bit
  logic                    in_cmd;       // Still inside the command field
  logic                    frame_end;

  assign in_cmd = (bit_cnt < CNT_BITS'(CMD_BITS));

  // Payload length lookup by command
  always_comb begin
    case (cmd_q)
      CMD_SKY:    payload_len = LEN_SKY;
      CMD_FLOOR:  payload_len = LEN_FLOOR;
      CMD_LEAK:   payload_len = LEN_LEAK;
      CMD_OTHER:  payload_len = LEN_OTHER;
      CMD_VSHIFT: payload_len = LEN_VSHIFT;
      CMD_MAPD:   payload_len = LEN_MAPD;
      default:    payload_len = LEN_VOPTS;  // VOPTS and unused codes 7..15
    endcase
  end

  assign last_bit  = CNT_BITS'(CMD_BITS) + payload_len - 1'b1;
  assign frame_end = (bit_cnt == last_bit);  // Never true while in_cmd

  // Bit counter stalls on the final payload bit
  always_ff @(posedge clk) begin
    if (reset || !i_ss_active) begin
      bit_cnt <= '0;
    end else if (i_sclk_rise && !frame_end) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Command shifter
  always_ff @(posedge clk) begin
    if (reset || !i_ss_active) begin
      cmd_q <= '0;
    end else if (i_sclk_rise && in_cmd) begin
      cmd_q <= {cmd_q[CMD_BITS-2:0], i_mosi};
    end
  end

  // Further rises after the end keep shifting the payload
  always_ff @(posedge clk) begin
    if (i_ss_active && i_sclk_rise && !in_cmd) begin
      rx_buf <= {rx_buf[PAYLOAD_BITS-2:0], i_mosi};
    end
  end

  // Done rises the cycle after the rise carrying the last bit
  always_ff @(posedge clk) begin
    if (reset || !i_ss_active) begin
      done_q <= 1'b0;
    end else begin
      done_q <= i_sclk_rise && frame_end;  // Rise pulses never come back to back
    end
  end

  assign o_frame_done = done_q;
  assign o_cmd        = cmd_q;
  assign o_payload    = rx_buf;  // Decoded downstream through the union views

endmodule

//--- verilog/spi_sync.sv
`timescale 1ns/1ps

module spi_sync #(
  parameter int SYNC_STAGES = 2  // At least 2
) (
  input  logic clk,
  input  logic reset,
  input  logic i_sclk,       // Raw SPI clock
  input  logic i_ss_n,       // Raw select, active low
  input  logic i_mosi,       // Raw data
  output logic o_sclk_rise,  // One-cycle pulse per SCLK rising edge
  output logic o_ss_active,  // Select level, active high
  output logic o_mosi        // Synchronised data
);

  // SCLK carries one stage more than the others for edge detection
  logic [SYNC_STAGES:0]   sclk_sync;
  logic [SYNC_STAGES-1:0] ss_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;

  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync <= '0;
      ss_sync   <= '1;  // Idle with select released
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[SYNC_STAGES-1:0], i_sclk};
      ss_sync   <= {ss_sync[SYNC_STAGES-2:0], i_ss_n};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], i_mosi};
    end
  end

  // Rise seen between the two oldest SCLK stages
  assign o_sclk_rise = (sclk_sync[SYNC_STAGES:SYNC_STAGES-1] == 2'b01);
  assign o_ss_active = ~ss_sync[SYNC_STAGES-1];
  assign o_mosi      = mosi_sync[SYNC_STAGES-1];  // Stable when o_sclk_rise fires

endmodule

//--- verilog/raybox_regs_pkg.sv
package raybox_regs_pkg;

  // Frame geometry
  localparam int CMD_BITS     = 4;   // Command field, sent MSB first
  localparam int PAYLOAD_BITS = 16;  // Receive buffer, sized for the MAPD payload
  localparam int CNT_BITS     = 5;   // Bit counter, covers CMD_BITS + PAYLOAD_BITS

  typedef logic [CMD_BITS-1:0] cmd_t;
  typedef logic [5:0]          rgb_t;      // {R[1:0], G[1:0], B[1:0]}
  typedef logic [5:0]          cell6_t;    // Map coordinate or texel count
  typedef logic [1:0]          wall_id_t;  // Wall texture ID

  // Command codes
  localparam cmd_t CMD_SKY    = 4'd0;
  localparam cmd_t CMD_FLOOR  = 4'd1;
  localparam cmd_t CMD_LEAK   = 4'd2;
  localparam cmd_t CMD_OTHER  = 4'd3;
  localparam cmd_t CMD_VSHIFT = 4'd4;
  localparam cmd_t CMD_VOPTS  = 4'd5;  // Codes 7..15 fall back to this length
  localparam cmd_t CMD_MAPD   = 4'd6;

  // Payload lengths in bits, following the command
  localparam logic [CNT_BITS-1:0] LEN_SKY    = 5'd6;
  localparam logic [CNT_BITS-1:0] LEN_FLOOR  = 5'd6;
  localparam logic [CNT_BITS-1:0] LEN_LEAK   = 5'd6;
  localparam logic [CNT_BITS-1:0] LEN_OTHER  = 5'd12;  // X then Y
  localparam logic [CNT_BITS-1:0] LEN_VSHIFT = 5'd6;
  localparam logic [CNT_BITS-1:0] LEN_VOPTS  = 5'd2;   // {vinf, leakfixed}
  localparam logic [CNT_BITS-1:0] LEN_MAPD   = 5'd16;

  // Views of the payload word, fields packed at the low end
  typedef struct packed {
    logic [PAYLOAD_BITS-7:0] unused;
    logic [5:0]              value;  // Sky, floor, leak or vshift
  } pay_single_t;

  typedef struct packed {
    logic [PAYLOAD_BITS-13:0] unused;
    cell6_t                   x;     // Last shifted in first, so X sits above Y
    cell6_t                   y;
  } pay_other_t;

  typedef struct packed {
    logic [PAYLOAD_BITS-3:0] unused;
    logic                    vinf;
    logic                    leakfixed;
  } pay_vopts_t;

  typedef struct packed {
    cell6_t   mapdx;  // Full 16 bits used
    cell6_t   mapdy;
    wall_id_t mapdxw;
    wall_id_t mapdyw;
  } pay_mapd_t;

  typedef union packed {
    pay_single_t single;
    pay_other_t  other;
    pay_vopts_t  vopts;
    pay_mapd_t   mapd;
  } payload_u;

endpackage
